/* rtl/fw_mem_pkg.sv */
// Shared bus widths, address map constants and region type for fw_mem
`default_nettype none

package fw_mem_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int DATA_W         = 32;
  localparam int BE_W           = 4;
  localparam int ADDR_W         = 12;

  // Word space of one target, 512 words
  localparam int RAM_ADDR_W     = 9;
  // Each firmware bank holds half of that
  localparam int FW_BANK_ADDR_W = 8;

  // Top address bits pick the region
  localparam int REGION_W       = ADDR_W - RAM_ADDR_W;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  // Word addresses 0x000 to 0x1ff
  localparam logic [REGION_W-1:0] REGION_FW  = 3'd0;
  // Word addresses 0x200 to 0x3ff
  localparam logic [REGION_W-1:0] REGION_APP = 3'd1;
  // Single word, one-way mode register
  localparam logic [ADDR_W-1:0]   MODE_ADDR  = 12'h800;

  // Decoded target of one request
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0,
    SEL_FW   = 2'd1,
    SEL_APP  = 2'd2,
    SEL_MODE = 2'd3
  } region_e;

endpackage

`default_nettype wire

/* rtl/mem_bus_if.sv */
// Interface for one target's select, byte enables, address and data
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

  // One-cycle request strobe
  logic                              cs;
  // Byte write enables, all zero for a read
  logic [fw_mem_pkg::BE_W-1:0]       we;
  // Word address inside the target
  logic [fw_mem_pkg::RAM_ADDR_W-1:0] address;
  logic [fw_mem_pkg::DATA_W-1:0]     write_data;
  // Valid in the cycle after cs
  logic [fw_mem_pkg::DATA_W-1:0]     read_data;

  // Decoder side
  modport ctrl (
    output cs, we, address, write_data,
    input  read_data
  );

  // Memory side
  modport target (
    input  cs, we, address, write_data,
    output read_data
  );

endinterface

`default_nettype wire

/* rtl/bank_ram.sv */
// Byte-maskable synchronous single-port RAM bank with configurable depth
`timescale 1ns/1ps
`default_nettype none

module bank_ram #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                               clk,
  input  wire                               en,
  input  wire [fw_mem_pkg::BE_W-1:0]        we,
  input  wire [ADDR_WIDTH-1:0]              addr,
  input  wire [fw_mem_pkg::DATA_W-1:0]      wdata,
  output logic [fw_mem_pkg::DATA_W-1:0]     rdata
);

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [fw_mem_pkg::DATA_W-1:0] mem [DEPTH];

  // ----------------------------------------------------------------------
  // Write port with byte lanes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < fw_mem_pkg::BE_W; i++) begin
        // Untouched lanes keep their old bytes
        if (we[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------
  // Only a read updates the output register
  always_ff @(posedge clk) begin
    if (en && !(|we)) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* rtl/fw_ram.sv */
// Two-bank firmware RAM with mode-based lock and access violation pulse
`timescale 1ns/1ps
`default_nettype none

module fw_ram (
  input  wire       clk,
  input  wire       reset_n,
  input  wire       system_mode,
  mem_bus_if.target bus,
  output logic      access_violation
);

  // ----------------------------------------------------------------------
  // Select qualification
  // ----------------------------------------------------------------------
  logic                          fw_cs;
  logic                          bank_sel;
  logic                          bank0_en;
  logic                          bank1_en;
  logic [fw_mem_pkg::DATA_W-1:0] bank0_rdata;
  logic [fw_mem_pkg::DATA_W-1:0] bank1_rdata;
  logic                          bank_reg;
  logic                          allowed_rd_reg;

  // Locked once system mode is entered
  assign fw_cs    = bus.cs && !system_mode;
  // Upper half of the word space lives in bank 1
  assign bank_sel = bus.address[fw_mem_pkg::FW_BANK_ADDR_W];
  assign bank0_en = fw_cs && !bank_sel;
  assign bank1_en = fw_cs && bank_sel;

  // ----------------------------------------------------------------------
  // Banks
  // ----------------------------------------------------------------------
  bank_ram #(.ADDR_WIDTH(fw_mem_pkg::FW_BANK_ADDR_W)) i_bank0 (
    .clk   (clk),
    .en    (bank0_en),
    .we    (bus.we),
    .addr  (bus.address[fw_mem_pkg::FW_BANK_ADDR_W-1:0]),
    .wdata (bus.write_data),
    .rdata (bank0_rdata)
  );

  bank_ram #(.ADDR_WIDTH(fw_mem_pkg::FW_BANK_ADDR_W)) i_bank1 (
    .clk   (clk),
    .en    (bank1_en),
    .we    (bus.we),
    .addr  (bus.address[fw_mem_pkg::FW_BANK_ADDR_W-1:0]),
    .wdata (bus.write_data),
    .rdata (bank1_rdata)
  );

  // ----------------------------------------------------------------------
  // Response registers
  // ----------------------------------------------------------------------
  // Bank choice follows the last permitted select
  always_ff @(posedge clk) begin
    if (fw_cs) begin
      bank_reg <= bank_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      allowed_rd_reg   <= 1'b0;
      access_violation <= 1'b0;
    end else begin
      // Data only for a permitted read
      allowed_rd_reg   <= fw_cs && !(|bus.we);
      // Any select in system mode is flagged
      access_violation <= bus.cs && system_mode;
    end
  end

  // Blocked accesses and writes read as zero
  assign bus.read_data = !allowed_rd_reg ? '0 :
                         (bank_reg ? bank1_rdata : bank0_rdata);

endmodule

`default_nettype wire

/* rtl/mem_ctrl.sv */
// Region decoder, one-way mode register, ready generation and read mux
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
  input  wire                                clk,
  input  wire                                reset_n,
  input  wire                                cs,
  input  wire [fw_mem_pkg::BE_W-1:0]         we,
  input  wire [fw_mem_pkg::ADDR_W-1:0]       address,
  input  wire [fw_mem_pkg::DATA_W-1:0]       write_data,
  output logic [fw_mem_pkg::DATA_W-1:0]      read_data,
  output logic                               ready,
  output logic                               system_mode,
  mem_bus_if.ctrl                            fw_bus,
  mem_bus_if.ctrl                            app_bus
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  fw_mem_pkg::region_e                 region;
  fw_mem_pkg::region_e                 region_reg;
  logic [fw_mem_pkg::REGION_W-1:0]     region_bits;
  logic                                is_read;
  logic                                rd_reg;
  logic                                mode_set;

  assign region_bits = address[fw_mem_pkg::ADDR_W-1:fw_mem_pkg::RAM_ADDR_W];
  assign is_read     = !(|we);

  always_comb begin
    // Mode register is a full-address match
    if (address == fw_mem_pkg::MODE_ADDR) begin
      region = fw_mem_pkg::SEL_MODE;
    end else if (region_bits == fw_mem_pkg::REGION_FW) begin
      region = fw_mem_pkg::SEL_FW;
    end else if (region_bits == fw_mem_pkg::REGION_APP) begin
      region = fw_mem_pkg::SEL_APP;
    end else begin
      region = fw_mem_pkg::SEL_NONE;
    end
  end

  // ----------------------------------------------------------------------
  // Target buses
  // ----------------------------------------------------------------------
  // Only the addressed target sees a select
  assign fw_bus.cs          = cs && (region == fw_mem_pkg::SEL_FW);
  assign fw_bus.we          = we;
  assign fw_bus.address     = address[fw_mem_pkg::RAM_ADDR_W-1:0];
  assign fw_bus.write_data  = write_data;

  assign app_bus.cs         = cs && (region == fw_mem_pkg::SEL_APP);
  assign app_bus.we         = we;
  assign app_bus.address    = address[fw_mem_pkg::RAM_ADDR_W-1:0];
  assign app_bus.write_data = write_data;

  // ----------------------------------------------------------------------
  // Mode register
  // ----------------------------------------------------------------------
  // Any byte enable counts, bit 0 carries the request
  assign mode_set = cs && (region == fw_mem_pkg::SEL_MODE) && !is_read && write_data[0];

  // Set once, cleared by reset only
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode <= 1'b0;
    end else if (mode_set) begin
      system_mode <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Response pipeline
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready      <= 1'b0;
      rd_reg     <= 1'b0;
      region_reg <= fw_mem_pkg::SEL_NONE;
    end else begin
      ready      <= cs;
      rd_reg     <= cs && is_read;
      // Idle cycles park the mux on none
      region_reg <= cs ? region : fw_mem_pkg::SEL_NONE;
    end
  end

  // Read data mux, zero for writes and unmapped words
  always_comb begin
    read_data = '0;
    if (rd_reg) begin
      case (region_reg)
        fw_mem_pkg::SEL_FW:   read_data = fw_bus.read_data;
        fw_mem_pkg::SEL_APP:  read_data = app_bus.read_data;
        // Mode bit reads back in bit 0
        fw_mem_pkg::SEL_MODE: read_data[0] = system_mode;
        default:              read_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/fw_mem_top.sv */
// Top level of the fw_mem memory subsystem with plain bus ports
`timescale 1ns/1ps
`default_nettype none

module fw_mem_top (
  input  wire                               clk,
  input  wire                               reset_n,
  input  wire                               cs,
  input  wire [fw_mem_pkg::BE_W-1:0]        we,
  input  wire [fw_mem_pkg::ADDR_W-1:0]      address,
  input  wire [fw_mem_pkg::DATA_W-1:0]      write_data,
  output wire [fw_mem_pkg::DATA_W-1:0]      read_data,
  output wire                               ready,
  output wire                               system_mode,
  output wire                               access_violation
);

  // ----------------------------------------------------------------------
  // Target buses
  // ----------------------------------------------------------------------
  mem_bus_if fw_bus ();
  mem_bus_if app_bus ();

  // Decoder, mode register and response path
  mem_ctrl i_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .ready       (ready),
    .system_mode (system_mode),
    .fw_bus      (fw_bus.ctrl),
    .app_bus     (app_bus.ctrl)
  );

  // Firmware RAM, locked in system mode
  fw_ram i_fw_ram (
    .clk              (clk),
    .reset_n          (reset_n),
    .system_mode      (system_mode),
    .bus              (fw_bus.target),
    .access_violation (access_violation)
  );

  // Application RAM, open in both modes
  bank_ram #(.ADDR_WIDTH(fw_mem_pkg::RAM_ADDR_W)) i_app_ram (
    .clk   (clk),
    .en    (app_bus.cs),
    .we    (app_bus.we),
    .addr  (app_bus.address),
    .wdata (app_bus.write_data),
    .rdata (app_bus.read_data)
  );

endmodule

`default_nettype wire

/* sim/fw_mem_checker.sv */
// Bound assertions on ready, mode and violation timing of fw_mem_top
`timescale 1ns/1ps
`default_nettype none

module fw_mem_checker (
  input wire clk,
  input wire reset_n,
  input wire cs,
  input wire ready,
  input wire system_mode,
  input wire access_violation
);

  // Failed assertions, read by the testbench at the end
  int unsigned error_count = 0;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  ready_after_cs: assert property (@(posedge clk) disable iff (!reset_n) cs |=> ready)
    else begin error_count++; $error("ready missing one cycle after cs"); end

  // No ready without a select in the cycle before
  ready_only_after_cs: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> $past(cs))
    else begin error_count++; $error("ready without a preceding cs"); end

  // ----------------------------------------------------------------------
  // Mode and violation
  // ----------------------------------------------------------------------
  mode_one_way: assert property (@(posedge clk) disable iff (!reset_n) !$fell(system_mode))
    else begin error_count++; $error("system_mode fell outside reset"); end

  violation_with_ready: assert property (@(posedge clk) disable iff (!reset_n)
    access_violation |-> ready)
    else begin error_count++; $error("access_violation high without ready"); end

  // First cycle out of reset sees cleared outputs
  clean_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> !ready && !system_mode && !access_violation)
    else begin error_count++; $error("outputs not cleared by reset"); end

endmodule

`default_nettype wire

/* sim/tb_fw_mem.sv */
// Testbench for fw_mem_top with reference memory model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_fw_mem;

  localparam int N_ITER  = 64;
  localparam int N_UNMAP = 16;
  // Prefill, four RAM phases, unmapped phase and mode phase
  localparam int N_TXN   = 1024 + 4 * 3 * N_ITER + 4 * N_UNMAP + 6;
  localparam int TIMEOUT = 2 * N_TXN + 16 + 64;

  logic                              clk;
  logic                              reset_n;
  logic                              cs;
  logic [fw_mem_pkg::BE_W-1:0]       we;
  logic [fw_mem_pkg::ADDR_W-1:0]     address;
  logic [fw_mem_pkg::DATA_W-1:0]     write_data;
  logic [fw_mem_pkg::DATA_W-1:0]     read_data;
  logic                              ready;
  logic                              system_mode;
  logic                              access_violation;

  // Both RAMs as one contiguous word space 0x000 to 0x3ff
  logic [31:0] ram_model [1024];
  logic        exp_mode = 1'b0;
  // Expected mode, violation and read data per request
  logic [33:0] exp_q [$];
  logic [33:0] resp;
  logic [31:0] seed = 32'hbfee2cc9;
  int          errors = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  fw_mem_top i_dut (
    .clk(clk), .reset_n(reset_n), .cs(cs), .we(we), .address(address),
    .write_data(write_data), .read_data(read_data), .ready(ready),
    .system_mode(system_mode), .access_violation(access_violation)
  );

  bind fw_mem_top fw_mem_checker i_checker (
    .clk(clk), .reset_n(reset_n), .cs(cs), .ready(ready),
    .system_mode(system_mode), .access_violation(access_violation)
  );

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // Target of a word address in the reference address map
  function automatic fw_mem_pkg::region_e target_of(input logic [11:0] addr);
    fw_mem_pkg::region_e sel;
    case (addr[11:9])
      fw_mem_pkg::REGION_FW:  sel = fw_mem_pkg::SEL_FW;
      fw_mem_pkg::REGION_APP: sel = fw_mem_pkg::SEL_APP;
      default:                sel = fw_mem_pkg::SEL_NONE;
    endcase
    if (addr == fw_mem_pkg::MODE_ADDR) begin
      sel = fw_mem_pkg::SEL_MODE;
    end
    return sel;
  endfunction

  // ----------------------------------------------------------------------
  // Request with model prediction
  // ----------------------------------------------------------------------
  task automatic issue(input logic [3:0] be, input logic [11:0] addr, input logic [31:0] data);
    logic [31:0]         exp_data;
    logic                exp_viol;
    fw_mem_pkg::region_e sel;
    exp_data = '0;
    exp_viol = 1'b0;
    sel      = target_of(addr);
    if (sel == fw_mem_pkg::SEL_MODE) begin
      // Bit 0 reads back and a write can only set it
      if (be == 4'h0) exp_data[0] = exp_mode;
      else if (data[0]) exp_mode = 1'b1;
    end else if (sel == fw_mem_pkg::SEL_FW && exp_mode) begin
      exp_viol = 1'b1;
    end else if (sel != fw_mem_pkg::SEL_NONE) begin
      if (be == 4'h0) exp_data = ram_model[addr[9:0]];
      for (int i = 0; i < 4; i++) begin
        if (be[i]) ram_model[addr[9:0]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
    exp_q.push_back({exp_mode, exp_viol, exp_data});
    @(posedge clk);
    #10;
    cs         = 1'b1;
    we         = be;
    address    = addr;
    write_data = data;
  endtask

  // Masked write, read back, then a random read in one region
  task automatic ram_traffic(input logic [2:0] region);
    logic [31:0] r;
    for (int i = 0; i < N_ITER; i++) begin
      r = next_rand();
      issue((r[31:28] == 4'h0) ? 4'h8 : r[31:28], {region, r[8:0]}, next_rand());
      issue(4'h0, {region, r[8:0]}, '0);
      issue(4'h0, {region, r[20:12]}, '0);
    end
  endtask

  task automatic unmapped_traffic();
    logic [31:0] r;
    logic [11:0] addr;
    for (int i = 0; i < N_UNMAP; i++) begin
      r    = next_rand();
      addr = {3'(32'd2 + r % 32'd6), r[20:12]};
      if (addr == fw_mem_pkg::MODE_ADDR) addr = addr + 12'd1;
      issue(4'hf, addr, next_rand());
      issue(4'h0, addr, '0);
      // Same offset in both RAMs must be untouched
      issue(4'h0, {fw_mem_pkg::REGION_FW, addr[8:0]}, '0);
      issue(4'h0, {fw_mem_pkg::REGION_APP, addr[8:0]}, '0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Response checks sampled mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (reset_n && ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected ready at %0t with no request pending", $time);
      end else begin
        resp = exp_q.pop_front();
        assert (read_data === resp[31:0]) else begin
          errors++;
          $display("[ERROR] %0t read_data %h, expected %h", $time, read_data, resp[31:0]);
        end
        assert (access_violation === resp[32]) else begin
          errors++;
          $display("[ERROR] %0t access_violation %b, expected %b", $time, access_violation,
                   resp[32]);
        end
        assert (system_mode === resp[33]) else begin
          errors++;
          $display("[ERROR] %0t system_mode %b, expected %b", $time, system_mode, resp[33]);
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = '0;
    address    = '0;
    write_data = '0;
    repeat (16) @(posedge clk);
    #10;
    reset_n = 1'b1;
    // Fill pattern spans every address bit
    for (int a = 0; a < 1024; a++) issue(4'hf, 12'(a), 32'(a) * 32'h9e3779b1);
    ram_traffic(fw_mem_pkg::REGION_FW);
    ram_traffic(fw_mem_pkg::REGION_APP);
    unmapped_traffic();
    // Mode register set only by bit 0
    issue(4'hf, fw_mem_pkg::MODE_ADDR, 32'hffff_fffe);
    issue(4'h0, fw_mem_pkg::MODE_ADDR, '0);
    issue(4'h1, fw_mem_pkg::MODE_ADDR, 32'h1);
    issue(4'h0, fw_mem_pkg::MODE_ADDR, '0);
    issue(4'hf, fw_mem_pkg::MODE_ADDR, '0);
    issue(4'h0, fw_mem_pkg::MODE_ADDR, '0);
    // System mode locks the firmware RAM
    ram_traffic(fw_mem_pkg::REGION_APP);
    ram_traffic(fw_mem_pkg::REGION_FW);
    @(posedge clk);
    #10;
    cs = 1'b0;
    we = '0;
    repeat (3) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("Requests left without ready: %0d", exp_q.size());
    end
    $display("Checks done: %0d testbench errors, %0d assertion errors", errors,
             i_dut.i_checker.error_count);
    if (errors == 0 && i_dut.i_checker.error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fw_mem.f */
rtl/fw_mem_pkg.sv
rtl/mem_bus_if.sv
rtl/bank_ram.sv
rtl/fw_ram.sv
rtl/mem_ctrl.sv
rtl/fw_mem_top.sv
sim/fw_mem_checker.sv
sim/tb_fw_mem.sv

/* Bender.yml */
package:
  name: fw_mem

sources:
  - rtl/fw_mem_pkg.sv
  - rtl/mem_bus_if.sv
  - rtl/bank_ram.sv
  - rtl/fw_ram.sv
  - rtl/mem_ctrl.sv
  - rtl/fw_mem_top.sv
  - target: simulation
    files:
      - sim/fw_mem_checker.sv
      - sim/tb_fw_mem.sv
